/* Bender.yml */
package:
  name: rr_arbiter

export_include_dirs:
  - common

sources:
  # packages first, then the converter, arbiter and top level
  - include_dirs:
      - common
    files:
      - common/thr_pkg.sv
      - common/arb_pkg.sv
      - logic/pry2thr.sv
      - arbiter/rr_arbiter.sv
      - logic/arb_top.sv

  # testbench
  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clkgen.sv
      - test/arb_tb.sv

/* arbiter/rr_arbiter.sv */
// round-robin and fixed priority selection

`timescale 1ns/1ps
`default_nettype none

module rr_arbiter
    import thr_pkg::*;
    import arb_pkg::*;
#(
    parameter int unsigned WIDTH          = 8,
    parameter thr_impl_e   IMPLEMENTATION = THR_ADDER,
    localparam int unsigned IDW           = (WIDTH > 1) ? $clog2(WIDTH) : 1
)(
    input  logic [WIDTH-1:0] req,      // request vector
    input  arb_mode_e        mode,     // fixed or round robin
    input  logic [IDW-1:0]   last_id,  // last round-robin winner
    output logic [WIDTH-1:0] gnt,      // one-hot grant
    output logic [IDW-1:0]   gnt_id,   // index of the grant
    output logic             found     // some request present
);

    //////////////////////////////////////////////////////////////////////
    // mask of indices above the last winner
    //////////////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] last_oh;   // one-hot of last winner
    logic [WIDTH-1:0] above_oh;  // one position higher
    logic [WIDTH-1:0] mask;      // all positions strictly above
    logic             mask_vld;  // zero when winner was the top index

    assign last_oh  = WIDTH'(1) << last_id;
    assign above_oh = last_oh << 1;  // top winner shifts out, mask empty

    pry2thr #(
        .WIDTH          (WIDTH),
        .DIRECTION      (THR_LSB),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_mask_thr (
        .pry (above_oh),
        .thr (mask),
        .vld (mask_vld)
    );

    //////////////////////////////////////////////////////////////////////
    // masked and unmasked request thermometers
    //////////////////////////////////////////////////////////////////////

    logic [WIDTH-1:0] req_msk;  // requests above the last winner
    logic [WIDTH-1:0] msk_thr;
    logic             msk_vld;
    logic [WIDTH-1:0] req_thr;
    logic             req_vld;

    assign req_msk = req & mask;

    pry2thr #(
        .WIDTH          (WIDTH),
        .DIRECTION      (THR_LSB),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_msk_thr (
        .pry (req_msk),
        .thr (msk_thr),
        .vld (msk_vld)
    );

    // full request set, used for fixed mode and for wrap-around
    pry2thr #(
        .WIDTH          (WIDTH),
        .DIRECTION      (THR_LSB),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_req_thr (
        .pry (req),
        .thr (req_thr),
        .vld (req_vld)
    );

    //////////////////////////////////////////////////////////////////////
    // selection
    //////////////////////////////////////////////////////////////////////

    logic             use_msk;  // take the masked thermometer
    logic [WIDTH-1:0] sel_thr;

    // fixed mode never looks at the mask
    assign use_msk = (mode == ARB_ROUND_ROBIN) && mask_vld && msk_vld;
    assign sel_thr = use_msk ? msk_thr : req_thr;

    // rising edge of the thermometer is the lowest set request
    assign gnt   = sel_thr & ~(sel_thr << 1);
    assign found = req_vld;

    //////////////////////////////////////////////////////////////////////
    // one-hot to index
    //////////////////////////////////////////////////////////////////////

    // OR of indices of set bits, exact for a one-hot input
    always_comb
    begin
        gnt_id = '0;
        for (int i = 0; i < WIDTH; i++)
        begin
            if (gnt[i])
            begin
                gnt_id = gnt_id | IDW'(i);
            end
        end
    end

endmodule : rr_arbiter

`default_nettype wire

/* common/arb_defines.svh */
// arbiter default parameters

`ifndef ARB_DEFINES_SVH
`define ARB_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// requester count
//////////////////////////////////////////////////////////////////////

// number of request lines seen by the top level
`define ARB_WIDTH 8

//////////////////////////////////////////////////////////////////////
// converter implementation
//////////////////////////////////////////////////////////////////////

// one of thr_pkg::THR_LOOP, thr_pkg::THR_VECTOR, thr_pkg::THR_ADDER
// the adder form is usually the smallest on FPGA carry chains
`define ARB_THR_IMPL thr_pkg::THR_ADDER

`endif

/* common/arb_pkg.sv */
// arbitration opcode type

`default_nettype none

package arb_pkg;

    // carried with every request strobe
    typedef enum logic
    {
        ARB_FIXED       = 1'b0,  // lowest index wins
        ARB_ROUND_ROBIN = 1'b1   // first index above last winner
    } arb_mode_e;

    // note that only round robin grants move the pointer,
    // fixed grants leave the rotation where it was

endpackage : arb_pkg

`default_nettype wire

/* common/thr_pkg.sv */
// thermometer converter types

`default_nettype none

package thr_pkg;

    // how the prefix OR is built
    typedef enum logic [1:0]
    {
        THR_LOOP   = 2'd0,  // ripple OR chain
        THR_VECTOR = 2'd1,  // log-step shifted OR
        THR_ADDER  = 2'd2   // two's complement trick
    } thr_impl_e;

    // which end of the vector has priority
    typedef enum logic
    {
        THR_LSB = 1'b0,  // fill upward from lowest set bit
        THR_MSB = 1'b1   // fill downward from highest set bit
    } thr_dir_e;

endpackage : thr_pkg

`default_nettype wire

/* filelist.f */
+incdir+common
common/thr_pkg.sv
common/arb_pkg.sv
logic/pry2thr.sv
arbiter/rr_arbiter.sv
logic/arb_top.sv
test/tb_clkgen.sv
test/arb_tb.sv

/* logic/arb_top.sv */
// arbiter top level

`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module arb_top
    import thr_pkg::*;
    import arb_pkg::*;
#(
    parameter int unsigned WIDTH          = `ARB_WIDTH,
    parameter thr_impl_e   IMPLEMENTATION = `ARB_THR_IMPL,
    localparam int unsigned IDW           = (WIDTH > 1) ? $clog2(WIDTH) : 1
)(
    input  wire logic             clk,
    input  wire logic             rst_n,    // sync, active low
    input  wire logic             req_stb,  // one-cycle request strobe
    input  wire logic [WIDTH-1:0] req,
    input  wire arb_mode_e        mode,
    output logic                  gnt_stb,  // one cycle after req_stb
    output logic      [WIDTH-1:0] gnt,      // one-hot
    output logic      [IDW-1:0]   gnt_id,
    output logic                  gnt_vld   // low when nothing requested
);

    //////////////////////////////////////////////////////////////////////
    // selection logic
    //////////////////////////////////////////////////////////////////////

    logic [IDW-1:0]   last_id;  // round-robin pointer
    logic [WIDTH-1:0] nxt_gnt;
    logic [IDW-1:0]   nxt_id;
    logic             nxt_found;

    rr_arbiter #(
        .WIDTH          (WIDTH),
        .IMPLEMENTATION (IMPLEMENTATION)
    ) u_arbiter (
        .req     (req),
        .mode    (mode),
        .last_id (last_id),
        .gnt     (nxt_gnt),
        .gnt_id  (nxt_id),
        .found   (nxt_found)
    );

    //////////////////////////////////////////////////////////////////////
    // grant registers and pointer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            gnt_stb <= 1'b0;
            gnt     <= '0;
            gnt_id  <= '0;
            gnt_vld <= 1'b0;
            last_id <= IDW'(WIDTH - 1);  // first rr grant starts at index 0
        end
        else
        begin
            gnt_stb <= req_stb;  // every strobe gets an answer
            if (req_stb)
            begin
                gnt     <= nxt_gnt;    // zero when no request
                gnt_id  <= nxt_id;
                gnt_vld <= nxt_found;
                // fixed grants leave the rotation alone
                if ((mode == ARB_ROUND_ROBIN) && nxt_found)
                begin
                    last_id <= nxt_id;
                end
            end
        end
    end

endmodule : arb_top

`default_nettype wire

/* logic/pry2thr.sv */
// priority to thermometer converter

`timescale 1ns/1ps
`default_nettype none

module pry2thr
    import thr_pkg::*;
#(
    parameter int unsigned WIDTH          = 8,
    parameter thr_dir_e    DIRECTION      = THR_LSB,
    parameter thr_impl_e   IMPLEMENTATION = THR_LOOP
)(
    input  logic [WIDTH-1:0] pry,  // priority vector
    output logic [WIDTH-1:0] thr,  // thermometer code
    output logic             vld   // any bit set
);

    //////////////////////////////////////////////////////////////////////
    // thermometer generation
    //////////////////////////////////////////////////////////////////////

    generate
        case (IMPLEMENTATION)
            THR_LOOP:
            begin : g_loop
                case (DIRECTION)
                    THR_LSB:
                    begin : g_lsb
                        always_comb
                        begin
                            logic run;
                            run = 1'b0;
                            for (int i = 0; i < WIDTH; i++)
                            begin
                                run    = run | pry[i];  // one OR per stage
                                thr[i] = run;
                            end
                        end
                    end
                    THR_MSB:
                    begin : g_msb
                        always_comb
                        begin
                            logic run;
                            run = 1'b0;
                            for (int i = WIDTH - 1; i >= 0; i--)
                            begin
                                run    = run | pry[i];
                                thr[i] = run;
                            end
                        end
                    end
                    default:
                        $fatal(1, "pry2thr: unsupported DIRECTION value");
                endcase
            end
            THR_VECTOR:
            begin : g_vector
                // doubling span each step, log2(WIDTH) levels deep
                case (DIRECTION)
                    THR_LSB:
                    begin : g_lsb
                        always_comb
                        begin
                            thr = pry;
                            for (int s = 1; s < WIDTH; s = s * 2)
                            begin
                                thr = thr | (thr << s);
                            end
                        end
                    end
                    THR_MSB:
                    begin : g_msb
                        always_comb
                        begin
                            thr = pry;
                            for (int s = 1; s < WIDTH; s = s * 2)
                            begin
                                thr = thr | (thr >> s);
                            end
                        end
                    end
                    default:
                        $fatal(1, "pry2thr: unsupported DIRECTION value");
                endcase
            end
            THR_ADDER:
            begin : g_adder
                logic [WIDTH-1:0] pry_lsb;  // input in LSB order
                logic [WIDTH-1:0] thr_lsb;  // result in LSB order

                // x | -x keeps the lowest set bit and everything above it
                assign thr_lsb = pry_lsb | (~pry_lsb + WIDTH'(1));

                case (DIRECTION)
                    THR_LSB:
                    begin : g_lsb
                        assign pry_lsb = pry;
                        assign thr     = thr_lsb;
                    end
                    THR_MSB:
                    begin : g_msb
                        // mirror in, mirror out
                        for (genvar i = 0; i < WIDTH; i++)
                        begin : g_rev
                            assign pry_lsb[i] = pry[WIDTH-1-i];
                            assign thr[i]     = thr_lsb[WIDTH-1-i];
                        end
                    end
                    default:
                        $fatal(1, "pry2thr: unsupported DIRECTION value");
                endcase
            end
            default:
                $fatal(1, "pry2thr: unsupported IMPLEMENTATION value");
        endcase
    endgenerate

    // far end of the thermometer is set only if some input bit was
    assign vld = (DIRECTION == THR_LSB) ? thr[WIDTH-1] : thr[0];

endmodule : pry2thr

`default_nettype wire

/* test/arb_tb.sv */
// arbiter testbench

`timescale 1ns/1ps
`default_nettype none

`include "arb_defines.svh"

module arb_tb
    import thr_pkg::*;
    import arb_pkg::*;
;

    localparam int WIDTH      = `ARB_WIDTH;
    localparam int IDW        = (WIDTH > 1) ? $clog2(WIDTH) : 1;
    localparam int RST_CYCLES = 16;
    localparam int NUM_RAND   = 400;
    localparam int MAX_GAP    = 3;
    // directed part stays well below this
    localparam int DIRECTED_CYCLES = 4 * WIDTH + 60;
    localparam int TIMEOUT_CYCLES  = RST_CYCLES + DIRECTED_CYCLES
                                     + NUM_RAND * (MAX_GAP + 1) + 100;

    logic             clk;
    logic             rst_n;
    logic             req_stb;
    logic [WIDTH-1:0] req;
    arb_mode_e        mode;
    logic             gnt_stb;
    logic [WIDTH-1:0] gnt;
    logic [IDW-1:0]   gnt_id;
    logic             gnt_vld;

    // expected answers, oldest first
    logic [WIDTH-1:0] exp_gnt_q[$];
    logic [IDW-1:0]   exp_id_q[$];
    logic             exp_vld_q[$];

    int     model_ptr = WIDTH - 1;  // reference copy of last_id
    int     value_errors = 0;
    int     proto_errors = 0;
    int     cycle_cnt = 0;
    integer seed = 71722;

    tb_clkgen #(
        .PERIOD_NS  (4.0),
        .RST_CYCLES (RST_CYCLES)
    ) u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    arb_top #(
        .WIDTH          (WIDTH),
        .IMPLEMENTATION (`ARB_THR_IMPL)
    ) uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req_stb (req_stb),
        .req     (req),
        .mode    (mode),
        .gnt_stb (gnt_stb),
        .gnt     (gnt),
        .gnt_id  (gnt_id),
        .gnt_vld (gnt_vld)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // plain search, first request above ptr then wrap to the bottom
    function automatic void ref_grant(input logic [WIDTH-1:0] r, input arb_mode_e m,
                                      input int ptr, output logic [WIDTH-1:0] g,
                                      output logic [IDW-1:0] id, output logic v);
        int win;
        win = -1;
        if (m == ARB_ROUND_ROBIN)
        begin
            for (int i = ptr + 1; i < WIDTH; i++)
            begin
                if (r[i] && win < 0)
                    win = i;
            end
        end
        for (int i = 0; i < WIDTH; i++)
        begin
            if (r[i] && win < 0)
                win = i;  // fixed mode or wrap-around
        end
        g  = '0;
        id = '0;
        v  = (win >= 0);
        if (v)
        begin
            g[win] = 1'b1;
            id     = IDW'(win);
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic send_req(input logic [WIDTH-1:0] r, input arb_mode_e m);
        logic [WIDTH-1:0] g;
        logic [IDW-1:0]   id;
        logic             v;
        @(posedge clk);
        #1;
        req_stb = 1'b1;
        req     = r;
        mode    = m;
        ref_grant(r, m, model_ptr, g, id, v);
        exp_gnt_q.push_back(g);
        exp_id_q.push_back(id);
        exp_vld_q.push_back(v);
        if (m == ARB_ROUND_ROBIN && v)
            model_ptr = id;  // only rr grants move the pointer
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge clk);
            #1;
            req_stb = 1'b0;
        end
    endtask

    task automatic check_value(input string name, input logic [WIDTH-1:0] exp_v,
                               input logic [WIDTH-1:0] act_v);
        assert (exp_v === act_v)
        else
        begin
            value_errors++;
            $display("ERROR: %s expected 0x%h actual 0x%h", name, exp_v, act_v);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checker
    //////////////////////////////////////////////////////////////////////

    logic             stb_seen = 1'b0;  // req_stb in the previous cycle
    logic [WIDTH-1:0] held_gnt = '0;
    logic [IDW-1:0]   held_id  = '0;
    logic             held_vld = 1'b0;

    // mid-cycle sampling, outputs settled since the rising edge
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (stb_seen)
            begin
                assert (gnt_stb)
                else
                begin
                    proto_errors++;
                    $display("gnt_stb missing one cycle after a request strobe");
                end
                held_gnt = exp_gnt_q.pop_front();
                held_id  = exp_id_q.pop_front();
                held_vld = exp_vld_q.pop_front();
            end
            else
            begin
                assert (!gnt_stb)
                else
                begin
                    proto_errors++;
                    $display("gnt_stb raised without a request strobe");
                end
            end
            // answer in its strobe cycle, then held until the next one
            check_value("gnt", held_gnt, gnt);
            check_value("gnt_id", WIDTH'(held_id), WIDTH'(gnt_id));
            check_value("gnt_vld", WIDTH'(held_vld), WIDTH'(gnt_vld));
        end
        stb_seen = req_stb;
    end

    // run limit
    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES)
        begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        logic [WIDTH-1:0] r;
        arb_mode_e        m;
        int               gap;

        req_stb = 1'b0;
        req     = '0;
        mode    = ARB_FIXED;

        wait (rst_n === 1'b1);
        idle_cycles(6);  // outputs must stay zero, no stray gnt_stb

        // all requesters, rr walks 0..WIDTH-1 then wraps
        for (int i = 0; i < WIDTH + 2; i++)
            send_req('1, ARB_ROUND_ROBIN);
        idle_cycles(2);

        // sparse requests
        send_req(WIDTH'(8'h92), ARB_ROUND_ROBIN);
        send_req(WIDTH'(8'h92), ARB_ROUND_ROBIN);
        send_req(WIDTH'(8'h92), ARB_ROUND_ROBIN);
        send_req(WIDTH'(8'h92), ARB_ROUND_ROBIN);
        send_req(WIDTH'(8'h05), ARB_ROUND_ROBIN);
        send_req(WIDTH'(8'h05), ARB_ROUND_ROBIN);
        idle_cycles(1);
        send_req(WIDTH'(8'h41), ARB_ROUND_ROBIN);
        idle_cycles(2);

        // fixed mode leaves the pointer where rr left it
        send_req(WIDTH'(8'hf0), ARB_FIXED);
        send_req('1, ARB_FIXED);
        send_req(WIDTH'(8'h18), ARB_FIXED);
        send_req('1, ARB_ROUND_ROBIN);
        idle_cycles(2);

        // empty request vectors
        send_req('0, ARB_ROUND_ROBIN);
        send_req('0, ARB_FIXED);
        send_req('1, ARB_ROUND_ROBIN);
        idle_cycles(3);

        // random traffic
        for (int n = 0; n < NUM_RAND; n++)
        begin
            r = WIDTH'($random(seed));
            if ($random(seed) & 1)
                r = r & WIDTH'($random(seed));  // sparser vectors
            m   = arb_mode_e'($random(seed) & 1);
            gap = $random(seed) & MAX_GAP;
            send_req(r, m);
            idle_cycles(gap);
        end
        idle_cycles(1);

        wait (exp_gnt_q.size() == 0);
        @(negedge clk);
        @(negedge clk);

        $display("errors: value %0d, protocol %0d, total %0d",
                 value_errors, proto_errors, value_errors + proto_errors);
        if (value_errors + proto_errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule : arb_tb

`default_nettype wire

/* test/tb_clkgen.sv */
// testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter real PERIOD_NS   = 4.0,
    parameter int  RST_CYCLES  = 16,
    parameter real DRIVE_DELAY = 1.0
)(
    output logic clk,
    output logic rst_n  // sync, active low
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // released just after an edge, like the other stimulus
    initial
    begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) rst_n = 1'b1;
    end

endmodule : tb_clkgen

`default_nettype wire
